// File: Bender.yml
package:
  name: mac_buffer

sources:
  - rtl/mac_pkg.sv
  - rtl/mac_ctlif.sv
  - rtl/mac_rx.sv
  - rtl/mac_tx.sv
  - rtl/mac_pktmem.sv
  - rtl/mac_top.sv
  - target: test
    files:
      - tb/tb_mac_top.sv

// File: files.f
rtl/mac_pkg.sv
rtl/mac_ctlif.sv
rtl/mac_rx.sv
rtl/mac_tx.sv
rtl/mac_pktmem.sv
rtl/mac_top.sv
tb/tb_mac_top.sv

// File: rtl/mac_ctlif.sv
////////////////////
// CSR block of the MAC. Window is csr_a[13:10] == csr_addr.
// Reads return data one cycle after the address, zero outside the window.
// A host write of code 2'b11 to a slot register is ignored.
// MII management is bit-banged through reg_mii.
////////////////////

`timescale 1ns/10ps

module mac_ctlif import mac_pkg::*; #(
	parameter logic [3:0] csr_addr = 4'h0
) (
	input  logic               sys_clk,
	input  logic               sys_rst,

	input  logic [13:0]        csr_a,
	input  logic               csr_we,
	input  logic [31:0]        csr_di,
	output logic [31:0]        csr_do,

	output logic               irq_rx,
	output logic               irq_tx,

	output logic [1:0]         rx_ready,
	input  logic [1:0]         rx_done,
	input  logic [count_w-1:0] rx_count_0,
	input  logic [count_w-1:0] rx_count_1,

	output logic               tx_start,
	input  logic               tx_done,
	output logic [count_w-1:0] tx_count,

	output logic               phy_mii_clk,
	inout  wire                phy_mii_data,
	output logic               phy_rst_n
);

	logic       phy_rst;      // High holds the PHY in reset.
	logic       mii_oe;       // MII data output enable.
	logic       mii_do;       // MII data driven out.
	logic       mii_di_meta;  // First sync stage.
	logic       mii_di;       // Synchronized MII data in.
	logic [1:0] slot0_state;
	logic [1:0] slot1_state;
	logic [1:0] armed_r;      // Armed bits, one cycle old.
	logic       tx_busy_r;    // tx_count nonzero, one cycle old.
	logic       csr_sel;

	assign phy_mii_data = mii_oe ? mii_do : 1'bz; // Open while input.
	assign phy_rst_n    = ~phy_rst;
	assign csr_sel      = (csr_a[13:10] == csr_addr);

	always_ff @(posedge sys_clk) begin
		mii_di_meta <= phy_mii_data; // Pad is asynchronous.
		mii_di      <= mii_di_meta;
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			csr_do      <= '0;
			phy_rst     <= 1'b1;
			phy_mii_clk <= 1'b0;
			mii_oe      <= 1'b0;
			mii_do      <= 1'b0;
			slot0_state <= slot_off;
			slot1_state <= slot_off;
			tx_count    <= '0;
		end else begin
			csr_do <= '0; // Idle bus reads zero.
			if (csr_sel) begin
				if (csr_we) begin
					case (csr_a[2:0])
						reg_phy_rst: phy_rst <= csr_di[0];
						reg_mii: begin
							phy_mii_clk <= csr_di[3];
							mii_oe      <= csr_di[2];
							mii_do      <= csr_di[0]; // Bit 1 is the input.
						end
						reg_slot0: if (csr_di[1:0] != 2'b11) slot0_state <= csr_di[1:0];
						reg_slot1: if (csr_di[1:0] != 2'b11) slot1_state <= csr_di[1:0];
						reg_tx_count: tx_count <= csr_di[count_w-1:0];
						default: ; // Counts are read only.
					endcase
				end
				case (csr_a[2:0])
					reg_phy_rst:  csr_do <= {31'd0, phy_rst};
					reg_mii:      csr_do <= {28'd0, phy_mii_clk, mii_oe, mii_di, mii_do};
					reg_slot0:    csr_do <= {30'd0, slot0_state};
					reg_count0:   csr_do <= {{(32-count_w){1'b0}}, rx_count_0};
					reg_slot1:    csr_do <= {30'd0, slot1_state};
					reg_count1:   csr_do <= {{(32-count_w){1'b0}}, rx_count_1};
					reg_tx_count: csr_do <= {{(32-count_w){1'b0}}, tx_count};
					default:      csr_do <= '0;
				endcase
			end
			// Completions win over a host write in the same cycle.
			if (rx_done[0]) slot0_state <= slot_full;
			if (rx_done[1]) slot1_state <= slot_full;
			if (tx_done)    tx_count    <= '0;
		end
	end

	// Edge detect on arming and on a fresh transmit count.
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			armed_r   <= 2'b00;
			tx_busy_r <= 1'b0;
		end else begin
			armed_r   <= {slot1_state == slot_armed, slot0_state == slot_armed};
			tx_busy_r <= |tx_count;
		end
	end

	assign rx_ready = {slot1_state == slot_armed, slot0_state == slot_armed} & ~armed_r;
	assign tx_start = (|tx_count) & ~tx_busy_r;

	assign irq_rx = (slot0_state == slot_full) | (slot1_state == slot_full);
	assign irq_tx = tx_done; // Single pulse per transmission.

	a_slot_code: assert property (@(posedge sys_clk) disable iff (sys_rst)
		(slot0_state != 2'b11) && (slot1_state != 2'b11));

endmodule

// File: rtl/mac_pkg.sv
////////////////////
// Shared constants for the MAC buffer subsystem.
// Byte counts are count_w bits wide, so they top out at 2047.
// Slot state code 2'b11 is never used.
////////////////////

package mac_pkg;

	localparam int count_w = 11; // Width of every byte count.

	// RX slot states.
	localparam logic [1:0] slot_off   = 2'b00; // Slot disabled.
	localparam logic [1:0] slot_armed = 2'b01; // Slot may take a frame.
	localparam logic [1:0] slot_full  = 2'b10; // Frame stored, irq raised.

	// Register indices, csr_a[2:0].
	localparam logic [2:0] reg_phy_rst  = 3'd0;
	localparam logic [2:0] reg_mii      = 3'd1; // {clk, oe, di, do}.
	localparam logic [2:0] reg_slot0    = 3'd2;
	localparam logic [2:0] reg_count0   = 3'd3; // Read only.
	localparam logic [2:0] reg_slot1    = 3'd4;
	localparam logic [2:0] reg_count1   = 3'd5; // Read only.
	localparam logic [2:0] reg_tx_count = 3'd6;

	// Upper bits of the host memory address.
	localparam logic [1:0] region_rx0 = 2'd0;
	localparam logic [1:0] region_rx1 = 2'd1;
	localparam logic [1:0] region_tx  = 2'd2;

endpackage

// File: rtl/mac_pktmem.sv
////////////////////
// Packet memory, three regions of 2**buf_aw bytes.
// Host reads of region 3 return zero.
// An RX engine write beats a host write to the same byte.
////////////////////

`timescale 1ns/10ps

module mac_pktmem import mac_pkg::*; #(
	parameter int buf_aw = 9
) (
	input  logic              sys_clk,

	input  logic [buf_aw+1:0] mem_a,
	input  logic              mem_we,
	input  logic [7:0]        mem_di,
	output logic [7:0]        mem_do,

	input  logic              rxm_we,
	input  logic              rxm_slot,
	input  logic [buf_aw-1:0] rxm_a,
	input  logic [7:0]        rxm_d,

	input  logic [buf_aw-1:0] txm_a,
	output logic [7:0]        txm_d
);

	localparam int depth = 1 << buf_aw;

	logic [7:0]        rx0_mem [0:depth-1];
	logic [7:0]        rx1_mem [0:depth-1];
	logic [7:0]        tx_mem  [0:depth-1];
	logic [1:0]        region;
	logic [buf_aw-1:0] off;

	assign region = mem_a[buf_aw+1:buf_aw];
	assign off    = mem_a[buf_aw-1:0];

	always_ff @(posedge sys_clk) begin
		if (mem_we && region == region_rx0) rx0_mem[off] <= mem_di;
		if (mem_we && region == region_rx1) rx1_mem[off] <= mem_di;
		if (mem_we && region == region_tx)  tx_mem[off]  <= mem_di;
		if (rxm_we && !rxm_slot) rx0_mem[rxm_a] <= rxm_d;
		if (rxm_we && rxm_slot)  rx1_mem[rxm_a] <= rxm_d;
	end

	always_ff @(posedge sys_clk) begin
		case (region)
			region_rx0: mem_do <= rx0_mem[off];
			region_rx1: mem_do <= rx1_mem[off];
			region_tx:  mem_do <= tx_mem[off];
			default:    mem_do <= 8'h00;
		endcase
		txm_d <= tx_mem[txm_a]; // TX engine sees only its region.
	end

endmodule

// File: rtl/mac_rx.sv
////////////////////
// Receive engine. The stream cannot stall, a byte is taken per rx_valid.
// Frames starting with no armed slot are dropped silently.
// Counts saturate at 2**buf_aw, or at 2047 when buf_aw is 11.
////////////////////

`timescale 1ns/10ps

module mac_rx import mac_pkg::*; #(
	parameter int buf_aw = 9
) (
	input  logic               sys_clk,
	input  logic               sys_rst,

	input  logic               rx_valid,
	input  logic [7:0]         rx_data,
	input  logic               rx_last,

	input  logic [1:0]         rx_ready,
	output logic [1:0]         rx_done,
	output logic [count_w-1:0] rx_count_0,
	output logic [count_w-1:0] rx_count_1,

	output logic               rxm_we,
	output logic               rxm_slot,
	output logic [buf_aw-1:0]  rxm_a,
	output logic [7:0]         rxm_d
);

	localparam logic [count_w-1:0] cnt_max =
		(buf_aw >= count_w) ? {count_w{1'b1}} : count_w'(1 << buf_aw);

	logic [1:0]         armed;    // Slot may take the next frame.
	logic               in_frame; // Past the first byte.
	logic               dropping; // Current frame has no slot.
	logic               cur_slot;
	logic [count_w-1:0] wr_cnt;   // Bytes seen so far, saturated.
	logic               sel_slot;
	logic               accept;
	logic [count_w-1:0] byte_cnt;
	logic               room;
	logic [count_w-1:0] next_cnt;

	assign sel_slot = in_frame ? cur_slot : ~armed[0]; // Slot 0 first.
	assign accept   = in_frame ? ~dropping : |armed;
	assign byte_cnt = in_frame ? wr_cnt : '0;
	assign room     = (byte_cnt < cnt_max);
	assign next_cnt = room ? byte_cnt + 1'b1 : byte_cnt;

	assign rxm_we   = rx_valid & accept & room; // Overflow bytes skip the RAM.
	assign rxm_slot = sel_slot;
	assign rxm_a    = byte_cnt[buf_aw-1:0];
	assign rxm_d    = rx_data;

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			armed      <= 2'b00;
			in_frame   <= 1'b0;
			dropping   <= 1'b0;
			cur_slot   <= 1'b0;
			wr_cnt     <= '0;
			rx_done    <= 2'b00;
			rx_count_0 <= '0;
			rx_count_1 <= '0;
		end else begin
			rx_done <= 2'b00;
			armed   <= armed | rx_ready;
			if (rx_valid) begin
				if (rx_last) begin
					in_frame <= 1'b0;
					dropping <= 1'b0;
					wr_cnt   <= '0;
					if (accept) begin
						rx_done         <= sel_slot ? 2'b10 : 2'b01;
						armed[sel_slot] <= 1'b0; // Host must rearm.
						if (sel_slot) rx_count_1 <= next_cnt;
						else          rx_count_0 <= next_cnt;
					end
				end else begin
					in_frame <= 1'b1;
					dropping <= ~accept; // Latched at the first byte.
					cur_slot <= sel_slot;
					wr_cnt   <= next_cnt;
				end
			end
		end
	end

	a_done_onehot: assert property (@(posedge sys_clk) disable iff (sys_rst)
		!(&rx_done));

endmodule

// File: rtl/mac_top.sv
////////////////////
// MAC buffer subsystem top. buf_aw is legal from 6 to 11.
// Host memory address is {region, byte offset}.
////////////////////

`timescale 1ns/10ps

module mac_top import mac_pkg::*; #(
	parameter logic [3:0] csr_addr = 4'h0,
	parameter int         buf_aw   = 9
) (
	input  logic              sys_clk,
	input  logic              sys_rst,
	input  logic [13:0]       csr_a,
	input  logic              csr_we,
	input  logic [31:0]       csr_di,
	output logic [31:0]       csr_do,
	output logic              irq_rx,
	output logic              irq_tx,
	input  logic [buf_aw+1:0] mem_a,
	input  logic              mem_we,
	input  logic [7:0]        mem_di,
	output logic [7:0]        mem_do,
	input  logic              rx_valid,
	input  logic [7:0]        rx_data,
	input  logic              rx_last,
	output logic              tx_valid,
	output logic [7:0]        tx_data,
	output logic              tx_last,
	input  logic              tx_ready,
	output logic              phy_mii_clk,
	inout  wire               phy_mii_data,
	output logic              phy_rst_n
);

	logic [1:0]         rx_ready, rx_done;
	logic [count_w-1:0] rx_count_0, rx_count_1, tx_count;
	logic               tx_start, tx_done;
	logic               rxm_we, rxm_slot;
	logic [buf_aw-1:0]  rxm_a, txm_a;
	logic [7:0]         rxm_d, txm_d;

	mac_ctlif #(.csr_addr(csr_addr)) u_ctlif (.*);

	mac_rx #(.buf_aw(buf_aw)) u_rx (.*);

	mac_tx #(.buf_aw(buf_aw)) u_tx (.*);

	mac_pktmem #(.buf_aw(buf_aw)) u_pktmem (.*);

endmodule

// File: rtl/mac_tx.sv
////////////////////
// Transmit engine. First tx_valid comes 2 cycles after tx_start.
// tx_count must not exceed the buffer size, the address wraps.
// The TX region should not be written while a transmission runs.
////////////////////

`timescale 1ns/10ps

module mac_tx import mac_pkg::*; #(
	parameter int buf_aw = 9
) (
	input  logic               sys_clk,
	input  logic               sys_rst,

	input  logic               tx_start,
	input  logic [count_w-1:0] tx_count,
	output logic               tx_done,

	output logic [buf_aw-1:0]  txm_a,
	input  logic [7:0]         txm_d,

	output logic               tx_valid,
	output logic [7:0]         tx_data,
	output logic               tx_last,
	input  logic               tx_ready
);

	logic [count_w-1:0] left;   // Bytes not yet loaded into tx_data.
	logic [buf_aw-1:0]  rd_idx; // Address that txm_d currently holds.
	logic               fire;
	logic               load;

	assign fire  = tx_valid & tx_ready;
	assign load  = (left != '0) & (~tx_valid | tx_ready); // Output empties.
	assign txm_a = load ? rd_idx + 1'b1 : rd_idx;          // Fetch one ahead.

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			left     <= '0;
			rd_idx   <= '0;
			tx_valid <= 1'b0;
			tx_last  <= 1'b0;
			tx_done  <= 1'b0;
		end else begin
			tx_done <= fire & tx_last;
			if (tx_start)  left <= tx_count;
			else if (load) left <= left - 1'b1;
			if (load) begin
				rd_idx   <= rd_idx + 1'b1;
				tx_valid <= 1'b1;
				tx_last  <= (left == count_w'(1));
			end else if (fire) begin
				tx_valid <= 1'b0;
				tx_last  <= 1'b0;
				if (tx_last) rd_idx <= '0; // Idle address is 0 for the next start.
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (load) tx_data <= txm_d;
	end

	a_hold: assert property (@(posedge sys_clk) disable iff (sys_rst)
		tx_valid && !tx_ready |=> tx_valid && $stable(tx_data) && $stable(tx_last));

endmodule

// File: tb/tb_mac_top.sv
////////////////////
// Directed testbench for mac_top with buf_aw 9 and CSR window 0.
// Inputs change on the falling edge and outputs are sampled there too.
// Random data and stalls come from one seeded $random stream.
////////////////////

`timescale 1ns/10ps

module tb_mac_top import mac_pkg::*; ();

	localparam logic [3:0] win    = 4'h0; // CSR window select.
	localparam int         buf_aw = 9;
	localparam int         bufsz  = 1 << buf_aw;

	logic              sys_clk, sys_rst;
	logic [13:0]       csr_a;
	logic              csr_we;
	logic [31:0]       csr_di, csr_do;
	logic              irq_rx, irq_tx;
	logic [buf_aw+1:0] mem_a;
	logic              mem_we;
	logic [7:0]        mem_di, mem_do;
	logic              rx_valid, rx_last;
	logic [7:0]        rx_data;
	logic              tx_valid, tx_last, tx_ready;
	logic [7:0]        tx_data;
	logic              phy_mii_clk, phy_rst_n;
	wire               phy_mii_data;
	logic              mii_en, mii_lvl; // PHY side of the MDIO line.

	logic [7:0]  frame [0:1023];
	integer      seed = 26;
	int          n_pass = 0;
	int          n_fail = 0;
	int          errs0;
	logic [31:0] rd;
	logic [7:0]  b;

	assign phy_mii_data = mii_en ? mii_lvl : 1'bz; // Only while DUT oe is low.

	mac_top #(.csr_addr(win), .buf_aw(buf_aw)) uut (.*);

	initial begin
		sys_clk = 1'b0;
		forever #10 sys_clk = ~sys_clk;
	end

	task check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			n_fail++;
			$display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
		end else n_pass++;
	endtask

	task end_test(input string name);
		$display("test %-12s %s", name, (n_fail == errs0) ? "ok" : "had errors");
		errs0 = n_fail;
	endtask

	task csr_write(input logic [2:0] idx, input logic [31:0] val);
		@(negedge sys_clk);
		csr_a  = {win, 7'd0, idx};
		csr_di = val;
		csr_we = 1'b1;
		@(negedge sys_clk); // Register updated at the edge between.
		csr_we = 1'b0;
	endtask

	task csr_read(input logic [2:0] idx, output logic [31:0] val);
		@(negedge sys_clk);
		csr_a = {win, 7'd0, idx};
		@(negedge sys_clk);
		val = csr_do; // One cycle read latency.
	endtask

	task mem_write(input logic [1:0] region, input int off, input logic [7:0] val);
		@(negedge sys_clk);
		mem_a  = {region, off[buf_aw-1:0]};
		mem_di = val;
		mem_we = 1'b1;
		@(negedge sys_clk);
		mem_we = 1'b0;
	endtask

	task mem_read(input logic [1:0] region, input int off, output logic [7:0] val);
		@(negedge sys_clk);
		mem_a = {region, off[buf_aw-1:0]};
		@(negedge sys_clk);
		val = mem_do;
	endtask

	task fill_frame(input int len);
		int r;
		for (int i = 0; i < len; i++) begin
			r = $random(seed);
			frame[i] = r[7:0];
		end
	endtask

	task arm_slot(input logic [2:0] idx);
		csr_write(idx, {30'd0, slot_armed});
		@(negedge sys_clk); // Ready pulse reaches the RX engine.
	endtask

	task send_frame(input int len);
		for (int i = 0; i < len; i++) begin
			@(negedge sys_clk);
			rx_valid = 1'b1;
			rx_data  = frame[i];
			rx_last  = (i == len - 1);
		end
		@(negedge sys_clk);
		rx_valid = 1'b0;
		rx_last  = 1'b0;
	endtask

	task wait_irq_rx(input logic level);
		int n;
		n = 0;
		while (irq_rx !== level && n < 50) begin
			@(negedge sys_clk);
			n++;
		end
		if (irq_rx !== level) begin
			n_fail++;
			$display("timeout: irq_rx did not go to %0d within 50 cycles", level);
		end
	endtask

	task check_region(input logic [1:0] region, input int len, input string tag);
		for (int i = 0; i < len; i++) begin
			mem_read(region, i, b);
			check_val($sformatf("mem_do[%s+%0d]", tag, i), b, frame[i]);
		end
	endtask

	task test_mgmt;
		check_val("phy_rst_n", phy_rst_n, 0); // PHY held after reset.
		check_val("irq_rx", irq_rx, 0);
		check_val("irq_tx", irq_tx, 0);
		csr_write(reg_phy_rst, 32'h0);
		check_val("phy_rst_n", phy_rst_n, 1);
		mii_en = 1'b0;
		csr_write(reg_mii, 32'hD); // Clock, enable and data high.
		check_val("phy_mii_data", phy_mii_data, 1);
		check_val("phy_mii_clk", phy_mii_clk, 1);
		csr_write(reg_mii, 32'h4);
		check_val("phy_mii_data", phy_mii_data, 0);
		check_val("phy_mii_clk", phy_mii_clk, 0);
		csr_write(reg_mii, 32'h0);
		mii_en  = 1'b1;
		mii_lvl = 1'b1;
		repeat (3) @(negedge sys_clk); // Two sync flops.
		csr_read(reg_mii, rd);
		check_val("csr_do[1]", rd[1], 1);
		mii_lvl = 1'b0;
		repeat (3) @(negedge sys_clk);
		csr_read(reg_mii, rd);
		check_val("csr_do[1]", rd[1], 0);
		end_test("management");
	endtask

	task test_rx_slot0;
		arm_slot(reg_slot0);
		fill_frame(40);
		send_frame(40);
		wait_irq_rx(1'b1);
		csr_read(reg_slot0, rd);
		check_val("slot0 state", rd, 2);
		csr_read(reg_count0, rd);
		check_val("count0", rd, 40);
		check_region(region_rx0, 40, "rx0");
		csr_write(reg_slot0, {30'd0, slot_off});
		wait_irq_rx(1'b0);
		end_test("rx_slot0");
	endtask

	task test_alternate;
		int n;
		arm_slot(reg_slot0);
		arm_slot(reg_slot1);
		fill_frame(17);
		send_frame(17);
		wait_irq_rx(1'b1);
		csr_read(reg_slot0, rd);
		check_val("slot0 state", rd, 2);
		csr_read(reg_slot1, rd);
		check_val("slot1 state", rd, 1); // Still waiting.
		check_region(region_rx0, 17, "rx0");
		fill_frame(23);
		send_frame(23);
		n = 0;
		rd = 0;
		while (rd !== 32'd2 && n < 20) begin
			csr_read(reg_slot1, rd);
			n++;
		end
		if (rd !== 32'd2) begin
			n_fail++;
			$display("timeout: slot 1 never became full after the second frame");
		end
		csr_read(reg_count1, rd);
		check_val("count1", rd, 23);
		check_region(region_rx1, 23, "rx1");
		fill_frame(12);
		send_frame(12); // No slot is armed so the frame vanishes.
		repeat (5) @(negedge sys_clk);
		csr_read(reg_count0, rd);
		check_val("count0", rd, 17);
		csr_read(reg_count1, rd);
		check_val("count1", rd, 23);
		csr_read(reg_slot0, rd);
		check_val("slot0 state", rd, 2);
		csr_read(reg_slot1, rd);
		check_val("slot1 state", rd, 2);
		csr_write(reg_slot0, {30'd0, slot_off});
		check_val("irq_rx", irq_rx, 1); // Slot 1 still full.
		csr_write(reg_slot1, {30'd0, slot_off});
		check_val("irq_rx", irq_rx, 0);
		end_test("alternate");
	endtask

	task test_oversize;
		arm_slot(reg_slot0);
		fill_frame(bufsz + 8);
		send_frame(bufsz + 8);
		wait_irq_rx(1'b1);
		csr_read(reg_count0, rd);
		check_val("count0", rd, bufsz); // Saturated at the buffer size.
		check_region(region_rx0, bufsz, "rx0");
		csr_write(reg_slot0, {30'd0, slot_off});
		end_test("oversize");
	endtask

	task test_tx;
		int got, n, r;
		logic seen_irq;
		fill_frame(33);
		for (int i = 0; i < 33; i++) mem_write(region_tx, i, frame[i]);
		csr_write(reg_tx_count, 33);
		got = 0;
		n = 0;
		seen_irq = 1'b0;
		while (!seen_irq && n < 1000) begin
			@(negedge sys_clk);
			n++;
			if (irq_tx) seen_irq = 1'b1;
			r = $random(seed);
			tx_ready = (r[1:0] != 2'b00); // Stall one cycle in four.
			if (tx_valid && tx_ready) begin
				if (got < 33) begin
					check_val($sformatf("tx_data[%0d]", got), tx_data, frame[got]);
					check_val($sformatf("tx_last[%0d]", got), tx_last, got == 32);
				end
				got++;
			end
		end
		tx_ready = 1'b0;
		if (!seen_irq) begin
			n_fail++;
			$display("timeout: irq_tx never pulsed within 1000 cycles");
		end
		check_val("tx_valid beats", got, 33);
		@(negedge sys_clk);
		check_val("irq_tx", irq_tx, 0); // One cycle pulse only.
		csr_read(reg_tx_count, rd);
		check_val("tx_count", rd, 0);
		end_test("tx_stall");
	endtask

	initial begin
		sys_rst  = 1'b1;
		csr_a    = '0;
		csr_we   = 1'b0;
		csr_di   = '0;
		mem_a    = '0;
		mem_we   = 1'b0;
		mem_di   = '0;
		rx_valid = 1'b0;
		rx_data  = '0;
		rx_last  = 1'b0;
		tx_ready = 1'b0;
		mii_en   = 1'b1;
		mii_lvl  = 1'b0;
		errs0    = 0;
		repeat (3) @(posedge sys_clk); // Three reset edges.
		@(negedge sys_clk);
		sys_rst = 1'b0;
		test_mgmt();
		test_rx_slot0();
		test_alternate();
		test_oversize();
		test_tx();
		$display("checks passed %0d, failed %0d", n_pass, n_fail);
		if (n_fail == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule
